/* hw/adc_capture_pkg.sv */
`default_nettype none

package adc_capture_pkg;

  localparam int SAMPLE_W    = 12;               // adc resolution
  localparam int LANE_W      = 16;               // storage per sample, zero-extended
  localparam int LANES       = 4;                // samples per beat
  localparam int BEAT_W      = LANES * LANE_W;   // 64-bit data beat
  localparam int BEAT_BYTES  = BEAT_W / 8;
  localparam int KEEP_W      = BEAT_BYTES;
  localparam int BURST_BEATS = 32;               // 256-byte block
  localparam int BTT_W       = 23;               // bytes-to-transfer field
  localparam int ADDR_W      = 32;
  localparam int TAG_W       = 4;
  localparam int STS_W       = 8;
  localparam int US_W        = 10;               // window length in us
  localparam int CMD_W       = 72;

  // s2mm command word layout, low bits first
  localparam int CMD_BTT_LSB  = 0;
  localparam int CMD_TYPE_BIT = 23;              // 1 = incrementing address
  localparam int CMD_DSA_LSB  = 24;
  localparam int CMD_DSA_W    = 6;
  localparam int CMD_EOF_BIT  = 30;
  localparam int CMD_DRR_BIT  = 31;
  localparam int CMD_ADDR_LSB = 32;
  localparam int CMD_TAG_LSB  = 64;
  localparam int CMD_RSVD_LSB = 68;
  localparam int CMD_RSVD_W   = 4;

  localparam int STS_OKAY_BIT = 7;               // status byte, tag sits in [3:0]

  localparam logic [KEEP_W-1:0] TKEEP_ALL = {KEEP_W{1'b1}};  // every byte valid

  typedef logic [SAMPLE_W-1:0] sample_t;

  // written lane by lane by the packer, read whole by the mover
  typedef union packed {
    logic [BEAT_W-1:0]            raw;
    logic [LANES-1:0][LANE_W-1:0] lane;          // lane 0 in the low bits
  } beat_u;

  typedef logic [CMD_W-1:0] cmd_t;

endpackage

`default_nettype wire

/* hw/capture_window.sv */
`default_nettype none

module capture_window import adc_capture_pkg::*; #(
  parameter int TICKS_PER_US = 200                // adc_clk cycles per microsecond
) (
  input  wire            adc_clk,
  input  wire            rst,
  input  wire            i_trig,                  // async trigger from outside
  input  wire [US_W-1:0] i_us_capture,            // window length in us
  output logic           o_sample_en,             // sample on i_adc_data is captured
  output logic           o_win_end,               // strobe after the last sample
  output logic           o_cap_done               // one pulse per window
);

  localparam int TICK_W = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CAPTURE,
    ST_DONE,
    ST_END
  } win_state_e;

  win_state_e        state;
  logic              trig_meta;                   // first sync stage
  logic              trig_sync;                   // trigger in adc_clk domain
  logic [TICK_W-1:0] tick_cnt;                    // cycles inside the current us
  logic [US_W-1:0]   us_cnt;                      // whole us already captured
  logic [US_W-1:0]   us_len;                      // length latched at the trigger
  logic              tick_wrap;
  logic              last_tick;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      trig_meta <= 1'b0;
      trig_sync <= 1'b0;
    end else begin
      trig_meta <= i_trig;
      trig_sync <= trig_meta;
    end
  end

  assign tick_wrap = (tick_cnt == TICK_W'(TICKS_PER_US - 1));
  assign last_tick = tick_wrap && (us_cnt == us_len - 1'b1);  // final sample cycle

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      tick_cnt    <= '0;
      us_cnt      <= '0;
      us_len      <= '0;
      o_sample_en <= 1'b0;
      o_win_end   <= 1'b0;
      o_cap_done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          tick_cnt <= '0;
          us_cnt   <= '0;
          us_len   <= i_us_capture;
          if (trig_sync) begin
            state <= (i_us_capture == '0) ? ST_DONE : ST_CAPTURE;  // zero length skips capture
          end
        end
        ST_CAPTURE: begin
          o_sample_en <= 1'b1;
          tick_cnt    <= tick_wrap ? '0 : tick_cnt + 1'b1;
          if (tick_wrap) us_cnt <= us_cnt + 1'b1;
          if (last_tick) state <= ST_DONE;
        end
        ST_DONE: begin
          o_sample_en <= 1'b0;
          o_win_end   <= 1'b1;
          o_cap_done  <= 1'b1;
          state       <= ST_END;
        end
        ST_END: begin
          o_win_end  <= 1'b0;
          o_cap_done <= 1'b0;
          state      <= ST_IDLE;                  // trigger seen again from next cycle
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // DONE always hands over to END, so a window cannot stretch its done pulse
  a_cap_done_single: assert property (@(posedge adc_clk) disable iff (rst)
    o_cap_done |=> !o_cap_done)
    else $error("capture_window: o_cap_done high for two cycles");

endmodule

`default_nettype wire

/* hw/sample_packer.sv */
`default_nettype none

module sample_packer import adc_capture_pkg::*; (
  input  wire          adc_clk,
  input  wire          rst,
  input  wire          i_sample_en,               // capture this cycle's sample
  input  wire          i_win_end,                 // window closed, flush the tail
  input  wire sample_t i_adc_data,
  output logic         o_wr_en,                   // fifo write strobe
  output beat_u        o_wr_beat,
  output logic         o_flushed                  // all beats of the window written
);

  localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [IDX_W-1:0] lane_idx;                     // next lane to fill
  beat_u            acc;                          // beat being assembled
  beat_u            acc_next;
  logic             beat_full;
  logic             tail_wr;                      // partial beat went out last cycle

  always_comb begin
    acc_next = acc;
    if (i_sample_en) begin
      acc_next.lane[lane_idx] = LANE_W'(i_adc_data);  // zero-extend into the lane
    end
  end

  assign beat_full = i_sample_en && (lane_idx == IDX_W'(LANES - 1));

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      lane_idx  <= '0;
      acc       <= '0;                            // unfilled lanes must read as zero
      o_wr_en   <= 1'b0;
      o_flushed <= 1'b0;
      tail_wr   <= 1'b0;
    end else begin
      o_wr_en   <= 1'b0;
      o_flushed <= tail_wr;                       // report one cycle after the tail write
      tail_wr   <= 1'b0;
      if (beat_full) begin
        o_wr_en  <= 1'b1;
        lane_idx <= '0;
        acc      <= '0;
      end else if (i_sample_en) begin
        lane_idx <= lane_idx + 1'b1;
        acc      <= acc_next;
      end else if (i_win_end) begin
        if (lane_idx != '0) begin                 // some lanes pending
          o_wr_en  <= 1'b1;
          tail_wr  <= 1'b1;
          lane_idx <= '0;
          acc      <= '0;
        end else begin
          o_flushed <= 1'b1;                      // nothing left, done right away
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (beat_full) begin
      o_wr_beat <= acc_next;                      // includes the fourth sample
    end else if (i_win_end) begin
      o_wr_beat <= acc;                           // tail, empty lanes already zero
    end
  end

endmodule

`default_nettype wire

/* hw/beat_fifo.sv */
`default_nettype none

module beat_fifo import adc_capture_pkg::*; #(
  parameter int FIFO_DEPTH = 64                   // beats held
) (
  input  wire                                  adc_clk,
  input  wire                                  rst,
  input  wire                                  i_wr_en,
  input  wire beat_u                           i_wr_beat,
  input  wire                                  i_rd_en,
  output beat_u                                o_rd_beat,   // head of queue, fall-through
  output logic [$clog2(FIFO_DEPTH + 1)-1:0]    o_count,
  output logic                                 o_empty,
  output logic                                 o_overflow   // sticky until rst
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  beat_u         mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth
  endfunction

  assign full      = (o_count == CW'(FIFO_DEPTH));
  assign o_empty   = (o_count == '0);
  assign do_wr     = i_wr_en && !full;            // write into a full buffer is lost
  assign do_rd     = i_rd_en && !o_empty;
  assign o_rd_beat = mem[rd_ptr];

  always_ff @(posedge adc_clk) begin
    if (do_wr) mem[wr_ptr] <= i_wr_beat;
  end

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_count    <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   o_count <= o_count + 1'b1;
        2'b01:   o_count <= o_count - 1'b1;
        default: o_count <= o_count;              // both or neither
      endcase
      if (i_wr_en && full) o_overflow <= 1'b1;
    end
  end

  // the writer only pops while it presents a valid beat from this buffer
  a_no_underflow: assert property (@(posedge adc_clk) disable iff (rst)
    i_rd_en |-> !o_empty)
    else $error("beat_fifo: read while empty");

endmodule

`default_nettype wire

/* hw/s2mm_writer.sv */
`default_nettype none

module s2mm_writer import adc_capture_pkg::*; #(
  parameter int                FIFO_DEPTH    = 64,
  parameter logic [TAG_W-1:0]  WR_TAG        = 4'b1010,        // command and status tag
  parameter logic [ADDR_W-1:0] DDR_BASE_ADDR = 32'h3400_0000   // first block
) (
  input  wire                               adc_clk,
  input  wire                               rst,
  input  wire [$clog2(FIFO_DEPTH + 1)-1:0]  i_count,          // beats buffered
  input  wire                               i_empty,
  input  wire beat_u                        i_rd_beat,
  input  wire                               i_flushed,        // window fully in the fifo
  input  wire                               i_cmd_tready,
  input  wire                               i_wr_tready,
  input  wire [STS_W-1:0]                   i_sts_tdata,
  input  wire                               i_sts_tvalid,
  input  wire                               i_sts_tlast,
  output logic                              o_rd_en,
  output cmd_t                              o_cmd_tdata,
  output logic                              o_cmd_tvalid,
  output logic [BEAT_W-1:0]                 o_wr_tdata,
  output logic [KEEP_W-1:0]                 o_wr_tkeep,
  output logic                              o_wr_tvalid,
  output logic                              o_wr_tlast,
  output logic                              o_wr_err          // sticky bad status
);

  localparam int CW   = $clog2(FIFO_DEPTH + 1);
  localparam int BL_W = $clog2(BURST_BEATS + 1);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_CMD,
    WR_DATA,
    WR_WAIT
  } wr_state_e;

  wr_state_e         state;
  logic              tail_pend;                   // flushed window may leave a short block
  logic [BL_W-1:0]   burst_len;                   // beats in the current burst
  logic [BL_W-1:0]   beat_cnt;                    // beats already sent
  logic [ADDR_W-1:0] wr_addr;                     // start of the next burst
  logic [BTT_W-1:0]  btt;
  logic              full_ready;
  logic              tail_ready;
  logic              last_beat;
  logic              sts_beat;
  logic              sts_bad;

  assign full_ready = (i_count >= CW'(BURST_BEATS));
  assign tail_ready = tail_pend && (i_count != '0);
  assign btt        = BTT_W'(burst_len) * BTT_W'(BEAT_BYTES);
  assign last_beat  = (beat_cnt == burst_len - 1'b1);
  assign sts_beat   = i_sts_tvalid && i_sts_tlast;
  assign sts_bad    = (i_sts_tdata[TAG_W-1:0] != WR_TAG) || !i_sts_tdata[STS_OKAY_BIT];

  always_comb begin
    o_cmd_tdata                              = '0;
    o_cmd_tdata[CMD_BTT_LSB +: BTT_W]        = btt;
    o_cmd_tdata[CMD_TYPE_BIT]                = 1'b1;   // incrementing
    o_cmd_tdata[CMD_DSA_LSB +: CMD_DSA_W]    = '0;
    o_cmd_tdata[CMD_EOF_BIT]                 = 1'b1;   // every burst is a frame
    o_cmd_tdata[CMD_DRR_BIT]                 = 1'b0;
    o_cmd_tdata[CMD_ADDR_LSB +: ADDR_W]      = wr_addr;
    o_cmd_tdata[CMD_TAG_LSB +: TAG_W]        = WR_TAG;
    o_cmd_tdata[CMD_RSVD_LSB +: CMD_RSVD_W]  = '0;
  end

  assign o_cmd_tvalid = (state == WR_CMD);
  assign o_wr_tvalid  = (state == WR_DATA) && !i_empty;  // only real beats go out
  assign o_wr_tlast   = o_wr_tvalid && last_beat;
  assign o_wr_tdata   = i_rd_beat.raw;
  assign o_wr_tkeep   = TKEEP_ALL;
  assign o_rd_en      = o_wr_tvalid && i_wr_tready;       // pop on handshake

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state     <= WR_IDLE;
      tail_pend <= 1'b0;
      burst_len <= '0;
      beat_cnt  <= '0;
      wr_addr   <= DDR_BASE_ADDR;
      o_wr_err  <= 1'b0;
    end else begin
      if (i_flushed) tail_pend <= 1'b1;
      if (sts_beat && sts_bad) o_wr_err <= 1'b1;
      case (state)
        WR_IDLE: begin
          beat_cnt <= '0;
          if (full_ready) begin                   // whole block goes before any tail
            burst_len <= BL_W'(BURST_BEATS);
            state     <= WR_CMD;
          end else if (tail_ready) begin
            burst_len <= BL_W'(i_count);          // below one block here
            tail_pend <= i_flushed;
            state     <= WR_CMD;
          end else if (tail_pend) begin
            tail_pend <= i_flushed;               // window ended on a block boundary
          end
        end
        WR_CMD: begin
          if (i_cmd_tready) begin
            wr_addr <= wr_addr + ADDR_W'(btt);
            state   <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (o_rd_en) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) state <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (sts_beat) state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // held beat comes from the fifo head, which must not move without a pop
  a_wr_hold: assert property (@(posedge adc_clk) disable iff (rst)
    o_wr_tvalid && !i_wr_tready |=> o_wr_tvalid && $stable(o_wr_tdata))
    else $error("s2mm_writer: data beat dropped or changed before accept");

endmodule

`default_nettype wire

/* hw/adc_capture_top.sv */
`default_nettype none

module adc_capture_top import adc_capture_pkg::*; #(
  parameter int                TICKS_PER_US  = 200,
  parameter int                FIFO_DEPTH    = 64,
  parameter logic [TAG_W-1:0]  WR_TAG        = 4'b1010,
  parameter logic [ADDR_W-1:0] DDR_BASE_ADDR = 32'h3400_0000
) (
  input  wire                adc_clk,
  input  wire                rst,
  input  wire                i_trig,
  input  wire [US_W-1:0]     i_us_capture,
  input  wire sample_t       i_adc_data,          // one deserialised sample per clock
  input  wire                i_cmd_tready,
  input  wire                i_wr_tready,
  input  wire [STS_W-1:0]    i_sts_tdata,
  input  wire                i_sts_tvalid,
  input  wire                i_sts_tlast,
  output logic               o_cap_done,
  output cmd_t               o_cmd_tdata,
  output logic               o_cmd_tvalid,
  output logic [BEAT_W-1:0]  o_wr_tdata,
  output logic [KEEP_W-1:0]  o_wr_tkeep,
  output logic               o_wr_tvalid,
  output logic               o_wr_tlast,
  output logic               o_wr_err,
  output logic               o_overflow
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic          sample_en;
  logic          win_end;
  logic          wr_en;
  beat_u         wr_beat;
  logic          flushed;
  beat_u         rd_beat;
  logic [CW-1:0] fifo_count;
  logic          fifo_empty;
  logic          rd_en;

  capture_window #(
    .TICKS_PER_US (TICKS_PER_US)
  ) u_capture_window (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_trig       (i_trig),
    .i_us_capture (i_us_capture),
    .o_sample_en  (sample_en),
    .o_win_end    (win_end),
    .o_cap_done   (o_cap_done)
  );

  sample_packer u_sample_packer (
    .adc_clk     (adc_clk),
    .rst         (rst),
    .i_sample_en (sample_en),
    .i_win_end   (win_end),
    .i_adc_data  (i_adc_data),
    .o_wr_en     (wr_en),
    .o_wr_beat   (wr_beat),
    .o_flushed   (flushed)
  );

  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_beat_fifo (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .i_wr_en    (wr_en),
    .i_wr_beat  (wr_beat),
    .i_rd_en    (rd_en),
    .o_rd_beat  (rd_beat),
    .o_count    (fifo_count),
    .o_empty    (fifo_empty),
    .o_overflow (o_overflow)
  );

  s2mm_writer #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .WR_TAG        (WR_TAG),
    .DDR_BASE_ADDR (DDR_BASE_ADDR)
  ) u_s2mm_writer (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_count      (fifo_count),
    .i_empty      (fifo_empty),
    .i_rd_beat    (rd_beat),
    .i_flushed    (flushed),
    .i_cmd_tready (i_cmd_tready),
    .i_wr_tready  (i_wr_tready),
    .i_sts_tdata  (i_sts_tdata),
    .i_sts_tvalid (i_sts_tvalid),
    .i_sts_tlast  (i_sts_tlast),
    .o_rd_en      (rd_en),
    .o_cmd_tdata  (o_cmd_tdata),
    .o_cmd_tvalid (o_cmd_tvalid),
    .o_wr_tdata   (o_wr_tdata),
    .o_wr_tkeep   (o_wr_tkeep),
    .o_wr_tvalid  (o_wr_tvalid),
    .o_wr_tlast   (o_wr_tlast),
    .o_wr_err     (o_wr_err)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40                       // full clock period
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD / 2) o_clk = ~o_clk;            // 50 % duty

endmodule

`default_nettype wire

/* testbench/tb_adc_capture.sv */
`default_nettype none

module tb_adc_capture import adc_capture_pkg::*;;

  localparam int          RESET_CYCLES = 16;
  localparam int          TICKS        = 8;       // cycles per us in this run
  localparam int          DEPTH        = 64;
  localparam logic [3:0]  TAG          = 4'b1010;
  localparam logic [31:0] BASE         = 32'h3400_0000;
  localparam int          POOL         = 1024;    // random samples reused cyclically
  localparam int          SUM_US       = 32 + 5 + 1 + 3 + 0 + 40 + 4 + 2;  // all windows
  localparam int          WINDOWS      = 8;
  localparam int          BURSTS       = 9;
  localparam int          LIMIT_CYCLES = 2 * (RESET_CYCLES + SUM_US * TICKS + WINDOWS * 40 +
                                              BURSTS * (BURST_BEATS + 8) + 64);

  logic              adc_clk;
  logic              rst;
  logic              i_trig;
  logic [US_W-1:0]   i_us_capture;
  sample_t           i_adc_data   = '0;
  logic              i_cmd_tready;
  logic              i_wr_tready;
  logic [STS_W-1:0]  i_sts_tdata  = '0;
  logic              i_sts_tvalid = 1'b0;
  logic              i_sts_tlast  = 1'b0;
  logic              o_cap_done;
  cmd_t              o_cmd_tdata;
  logic              o_cmd_tvalid;
  logic [BEAT_W-1:0] o_wr_tdata;
  logic [KEEP_W-1:0] o_wr_tkeep;
  logic              o_wr_tvalid;
  logic              o_wr_tlast;
  logic              o_wr_err;
  logic              o_overflow;

  sample_t           pool [POOL];
  sample_t           exp_samples [$];             // samples inside any window in capture order
  cmd_t              got_cmds [$];
  beat_u             got_beats [$];
  logic              got_lasts [$];
  logic [KEEP_W-1:0] got_keeps [$];
  int                cap_pulses = 0;
  int                sts_sent   = 0;
  int                cycle_cnt  = 0;
  int                pool_idx   = 0;
  int                win_lead   = 0;              // cycles left before the first sample
  int                win_left   = 0;              // samples still to record
  logic              trig_seen  = 1'b0;
  logic [7:0]        sts_reply;                   // status byte the mover returns
  logic [31:0]       next_addr;                   // where the next burst should land
  int                s_mark;
  int                b_mark;
  int                c_mark;
  int                st_mark;

  tb_clock_gen #(.PERIOD(40)) u_clock_gen (.o_clk(adc_clk));

  adc_capture_top #(
    .TICKS_PER_US  (TICKS),
    .FIFO_DEPTH    (DEPTH),
    .WR_TAG        (TAG),
    .DDR_BASE_ADDR (BASE)
  ) UUT (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .i_trig       (i_trig),
    .i_us_capture (i_us_capture),
    .i_adc_data   (i_adc_data),
    .i_cmd_tready (i_cmd_tready),
    .i_wr_tready  (i_wr_tready),
    .i_sts_tdata  (i_sts_tdata),
    .i_sts_tvalid (i_sts_tvalid),
    .i_sts_tlast  (i_sts_tlast),
    .o_cap_done   (o_cap_done),
    .o_cmd_tdata  (o_cmd_tdata),
    .o_cmd_tvalid (o_cmd_tvalid),
    .o_wr_tdata   (o_wr_tdata),
    .o_wr_tkeep   (o_wr_tkeep),
    .o_wr_tvalid  (o_wr_tvalid),
    .o_wr_tlast   (o_wr_tlast),
    .o_wr_err     (o_wr_err),
    .o_overflow   (o_overflow)
  );

  // a trigger seen at edge T makes the samples driven from T+3 onward count
  always @(posedge adc_clk) begin : drive_samples
    if (win_lead != 0) win_lead = win_lead - 1;
    if (win_lead == 0 && win_left != 0) begin
      exp_samples.push_back(pool[pool_idx]);
      win_left = win_left - 1;
    end
    i_adc_data <= pool[pool_idx];
    pool_idx = (pool_idx + 1) % POOL;
    if (i_trig && !trig_seen) begin
      win_lead = 3;
      win_left = int'(i_us_capture) * TICKS;
    end
    trig_seen = i_trig;
  end

  // memory mover model that answers each burst with one status beat
  always @(posedge adc_clk) begin : mover_model
    beat_u b;
    i_sts_tvalid <= 1'b0;
    i_sts_tlast  <= 1'b0;
    if (o_cap_done) cap_pulses = cap_pulses + 1;
    if (o_cmd_tvalid && i_cmd_tready) got_cmds.push_back(o_cmd_tdata);
    if (o_wr_tvalid && i_wr_tready) begin
      b.raw = o_wr_tdata;
      got_beats.push_back(b);
      got_lasts.push_back(o_wr_tlast);
      got_keeps.push_back(o_wr_tkeep);
      if (o_wr_tlast) begin
        i_sts_tvalid <= 1'b1;
        i_sts_tlast  <= 1'b1;
        i_sts_tdata  <= sts_reply;
        sts_sent = sts_sent + 1;
      end
    end
  end

  always @(posedge adc_clk) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= LIMIT_CYCLES) begin
      stop_with_error($sformatf("timeout, run did not finish within %0d cycles", LIMIT_CYCLES));
    end
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_beat(input string name, input beat_u got, input beat_u exp);
    if (got.raw !== exp.raw) begin
      stop_with_error($sformatf("error at %0t: %s got %h expected %h", $time, name,
                                got.raw, exp.raw));
    end
  endtask

  task automatic check_keep(input string name, input logic [KEEP_W-1:0] got,
                            input logic [KEEP_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_error($sformatf("error at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // command fields from high bits to low are rsvd tag addr drr eof dsa type btt
  function automatic cmd_t build_cmd(input int bytes, input logic [31:0] addr);
    return {4'b0000, TAG, addr, 1'b0, 1'b1, 6'b000000, 1'b1, 23'(bytes)};
  endfunction

  task automatic take_marks();
    s_mark  = exp_samples.size();
    b_mark  = got_beats.size();
    c_mark  = got_cmds.size();
    st_mark = sts_sent;
  endtask

  task automatic open_window(input int us);
    int pulses;
    pulses = cap_pulses;
    i_us_capture <= US_W'(us);
    i_trig       <= 1'b1;
    @(posedge adc_clk);
    i_trig <= 1'b0;
    while (cap_pulses == pulses) @(posedge adc_clk);
    repeat (2) @(posedge adc_clk);               // trigger is ignored until then
  endtask

  task automatic await_bursts(input int n);
    while (sts_sent < st_mark + n) @(posedge adc_clk);
    repeat (2) @(posedge adc_clk);               // writer is back in idle once status is taken
  endtask

  // four samples per beat with lane 0 lowest, in blocks of 32 and then the tail
  task automatic score_window(input int m);
    beat_u exp_b;
    int    idx;
    int    len;
    int    nb;
    logic  exp_last;
    compare_count("data beats", got_beats.size() - b_mark, m);
    for (int b = 0; b < m; b++) begin
      exp_b = '0;
      for (int l = 0; l < LANES; l++) begin
        idx = s_mark + 4 * b + l;
        if (idx < exp_samples.size()) exp_b.lane[l] = {4'b0000, exp_samples[idx]};
      end
      exp_last = (b % BURST_BEATS == BURST_BEATS - 1) || (b == m - 1);
      check_beat($sformatf("o_wr_tdata beat %0d", b), got_beats[b_mark + b], exp_b);
      check_flag($sformatf("o_wr_tlast beat %0d", b), got_lasts[b_mark + b], exp_last);
      check_keep($sformatf("o_wr_tkeep beat %0d", b), got_keeps[b_mark + b], 8'hff);
    end
    nb = (m + BURST_BEATS - 1) / BURST_BEATS;
    compare_count("commands", got_cmds.size() - c_mark, nb);
    for (int k = 0; k < nb; k++) begin
      len = (m - BURST_BEATS * k > BURST_BEATS) ? BURST_BEATS : m - BURST_BEATS * k;
      check_cmd($sformatf("o_cmd_tdata burst %0d", k), got_cmds[c_mark + k],
                build_cmd(8 * len, next_addr));
      next_addr = next_addr + 32'(8 * len);
    end
  endtask

  task automatic outputs_idle_after_reset();
    @(negedge adc_clk);
    check_flag("o_cmd_tvalid", o_cmd_tvalid, 1'b0);
    check_flag("o_wr_tvalid", o_wr_tvalid, 1'b0);
    check_flag("o_wr_tlast", o_wr_tlast, 1'b0);
    check_flag("o_wr_err", o_wr_err, 1'b0);
    check_flag("o_cap_done", o_cap_done, 1'b0);
    check_flag("o_overflow", o_overflow, 1'b0);
    @(posedge adc_clk);
  endtask

  task automatic full_block_bursts();
    take_marks();
    open_window(32);                              // 256 samples make 64 beats
    await_bursts(2);
    score_window(64);
  endtask

  task automatic short_tail_burst();
    int pulses;
    take_marks();
    pulses = cap_pulses;
    open_window(5);                               // 40 samples make 10 beats
    await_bursts(1);
    score_window(10);
    compare_count("o_cap_done pulses", cap_pulses - pulses, 1);
  endtask

  task automatic two_small_windows();
    take_marks();
    open_window(1);
    await_bursts(1);
    score_window(2);
    take_marks();
    open_window(3);                               // address carries on from above
    await_bursts(1);
    score_window(6);
  endtask

  task automatic zero_length_window();
    int pulses;
    take_marks();
    pulses = cap_pulses;
    open_window(0);
    repeat (16) @(posedge adc_clk);               // give a stray command time to show
    @(negedge adc_clk);
    compare_count("commands", got_cmds.size() - c_mark, 0);
    compare_count("o_cap_done pulses", cap_pulses - pulses, 1);
    check_flag("o_overflow", o_overflow, 1'b0);
  endtask

  task automatic back_pressure_overflow();
    take_marks();
    i_cmd_tready <= 1'b0;
    i_wr_tready  <= 1'b0;
    open_window(40);                              // 80 beats into a 64 deep fifo
    @(negedge adc_clk);
    check_flag("o_overflow", o_overflow, 1'b1);
    @(posedge adc_clk);
    i_cmd_tready <= 1'b1;
    i_wr_tready  <= 1'b1;
    await_bursts(2);
    score_window(DEPTH);                          // only the beats that fit
    take_marks();
    open_window(4);
    await_bursts(1);
    score_window(8);
    @(negedge adc_clk);
    check_flag("o_overflow", o_overflow, 1'b1);   // sticky
  endtask

  task automatic bad_status_tag();
    @(negedge adc_clk);
    check_flag("o_wr_err", o_wr_err, 1'b0);
    @(posedge adc_clk);
    sts_reply <= {1'b1, 3'b000, ~TAG};
    take_marks();
    open_window(2);
    await_bursts(1);
    score_window(4);
    @(negedge adc_clk);
    check_flag("o_wr_err", o_wr_err, 1'b1);
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    check_flag("o_wr_err", o_wr_err, 1'b1);
  endtask

  initial begin
    void'($urandom(19));
    for (int i = 0; i < POOL; i++) begin
      pool[i] = sample_t'($urandom);
    end
    rst          = 1'b1;
    i_trig       = 1'b0;
    i_us_capture = '0;
    i_cmd_tready = 1'b1;
    i_wr_tready  = 1'b1;
    sts_reply    = {1'b1, 3'b000, TAG};           // okay bit and matching tag
    next_addr    = BASE;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    rst <= 1'b0;
    repeat (4) @(posedge adc_clk);
    outputs_idle_after_reset();
    full_block_bursts();
    short_tail_burst();
    two_small_windows();
    zero_length_window();
    back_pressure_overflow();
    bad_status_tag();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/adc_capture_pkg.sv
hw/capture_window.sv
hw/sample_packer.sv
hw/beat_fifo.sv
hw/s2mm_writer.sv
hw/adc_capture_top.sv
testbench/tb_clock_gen.sv
testbench/tb_adc_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the adc capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_adc_capture \
  --Mdir obj_dir -o tb_adc_capture > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_adc_capture > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  exit 1
fi
exit 0
